//--- flist.f
verilog/trig_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/cmd_parser.sv
verilog/trig_regs.sv
verilog/pulse_gen.sv
verilog/trig_ctrl_top.sv
verification/tb_trig_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --timescale 1ns/100ps \
	--top-module tb_trig_ctrl -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
	exit 0
fi
exit 1

//--- verification/tb_trig_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module tb_trig_ctrl;

	import trig_pkg::*;

	localparam int clks_per_bit = 8;
	localparam int pulse_div = 4;
	localparam int n_frames = 21;
	localparam int n_bursts = 2;
	localparam int max_count = 6;
	localparam int timeout_cycles =
		(n_frames * 8 * 10 * clks_per_bit + n_bursts * max_count * 9 * pulse_div) * 3 / 2;

	logic clk = 1'b0;
	logic nrst;
	logic rx;
	logic tx;
	logic [num_chan-1:0] trig_out;
	vctr_t vctr_out;

	logic [31:0] rng_state;
	trig_type_e model_type [num_chan];
	logic [7:0] model_count [num_chan];
	vctr_t model_vec;
	logic [7:0] exp_q [$]; // reply bytes still to come, in order.
	logic [num_chan-1:0] trig_prev;
	int rise_cnt [num_chan];
	int fall_cnt [num_chan];
	int rise_base [num_chan];
	int fall_base [num_chan];
	int main_checks;
	int main_errors;
	int reply_checks;
	int reply_errors;

	trig_ctrl_top #(
		.clks_per_bit(clks_per_bit),
		.pulse_div(pulse_div)
	) i_dut (
		.clk(clk),
		.nrst(nrst),
		.rx(rx),
		.tx(tx),
		.trig_out(trig_out),
		.vctr_out(vctr_out)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic frame_is_valid(input logic [3:0][7:0] frm);
		logic op_ok;
		case (frm[0])
			OP_READ, OP_WRITE, OP_FIRE: op_ok = 1'b1;
			OP_CONFIG: op_ok = (frm[2] < 8'd3); // type byte must name a real type.
			default: op_ok = 1'b0;
		endcase
		return op_ok && (frm[1] < 8'(num_chan));
	endfunction

	function automatic logic [3:0][7:0] expected_reply(input logic [3:0][7:0] frm);
		logic [3:0][7:0] r;
		if (!frame_is_valid(frm)) begin
			r = {4{8'hFF}};
		end else if (frm[0] == OP_READ) begin
			r[0] = frm[0];
			r[1] = frm[1];
			r[2] = model_vec[frm[1][1:0]];
			r[3] = 8'h00;
		end else begin
			r = frm;
		end
		return r;
	endfunction

	function automatic int expected_pulses(input int ch);
		if (model_type[ch] == TRIG_OFF || model_count[ch] == 8'd0) begin
			return 0;
		end
		return int'(model_count[ch]);
	endfunction

	function automatic void update_model(input logic [3:0][7:0] frm);
		int ch;
		ch = int'(frm[1][1:0]);
		if (frame_is_valid(frm)) begin
			case (frm[0])
				OP_WRITE: model_vec[ch] = frm[2];
				OP_CONFIG: begin
					model_type[ch] = trig_type_e'(frm[2][1:0]);
					model_count[ch] = frm[3];
				end
				default: ;
			endcase
		end
	endfunction

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
		reply_checks++;
		if (got !== exp) begin
			reply_errors++;
			$display("FAIL tx: got 0x%02h, expected 0x%02h", got, exp);
		end
	endtask

	task automatic check_vector(input vctr_t got, input vctr_t exp);
		main_checks++;
		if (got !== exp) begin
			main_errors++;
			$display("FAIL vctr_out: got 0x%08h, expected 0x%08h", got, exp);
		end
	endtask

	task automatic check_pulses(input int ch, input int got_n, input int exp_n,
		input logic got_rest, input logic exp_rest);
		main_checks++;
		if (got_n != exp_n) begin
			main_errors++;
			$display("FAIL trig_out[%0d] pulses: got 0x%0h, expected 0x%0h", ch, got_n, exp_n);
		end
		main_checks++;
		if (got_rest !== exp_rest) begin
			main_errors++;
			$display("FAIL trig_out[%0d] rest: got 0x%0h, expected 0x%0h", ch, got_rest,
				exp_rest);
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0}; // stop, data, start.
		for (int i = 0; i < 10; i++) begin
			rx = bits[i];
			repeat (clks_per_bit) @(negedge clk);
		end
	endtask

	task automatic capture_byte(output logic [7:0] b, output logic stop_bit);
		@(negedge clk);
		while (tx !== 1'b0) begin
			@(negedge clk);
		end
		repeat (clks_per_bit / 2) @(negedge clk); // middle of the start bit.
		for (int i = 0; i < 8; i++) begin
			repeat (clks_per_bit) @(negedge clk);
			b[i] = tx;
		end
		repeat (clks_per_bit) @(negedge clk);
		stop_bit = tx;
	endtask

	// reply monitor, checks each byte against the queue
	always begin : reply_monitor
		logic [7:0] got;
		logic stop_bit;
		logic [7:0] exp;
		capture_byte(got, stop_bit);
		if (stop_bit !== 1'b1) begin
			reply_checks++;
			reply_errors++;
			$display("reply byte on tx has no stop bit");
		end
		if (exp_q.size() == 0) begin
			reply_errors++;
			$display("tx sent byte 0x%02h while no reply was pending", got);
		end else begin
			exp = exp_q.pop_front();
			check_byte(got, exp);
		end
	end

	always @(negedge clk) begin : edge_counter
		for (int i = 0; i < num_chan; i++) begin
			if (trig_prev[i] === 1'b0 && trig_out[i] === 1'b1) begin
				rise_cnt[i] <= rise_cnt[i] + 1;
			end
			if (trig_prev[i] === 1'b1 && trig_out[i] === 1'b0) begin
				fall_cnt[i] <= fall_cnt[i] + 1;
			end
		end
		trig_prev <= trig_out;
	end

	task automatic run_frame(input logic [7:0] op, input logic [7:0] ch,
		input logic [7:0] a1, input logic [7:0] a2);
		logic [3:0][7:0] frm;
		logic [3:0][7:0] exp;
		frm = {a2, a1, ch, op};
		exp = expected_reply(frm);
		for (int i = 0; i < 4; i++) begin
			exp_q.push_back(exp[i]);
		end
		update_model(frm);
		for (int i = 0; i < 4; i++) begin
			send_byte(frm[i]);
		end
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic wait_quiet();
		logic [num_chan-1:0] last;
		int quiet;
		quiet = 0;
		last = trig_out;
		while (quiet < 12 * pulse_div) begin // longer than any gap inside a burst.
			@(negedge clk);
			if (trig_out === last) begin
				quiet++;
			end else begin
				quiet = 0;
				last = trig_out;
			end
		end
	endtask

	task automatic snapshot_edges();
		for (int i = 0; i < num_chan; i++) begin
			rise_base[i] = rise_cnt[i];
			fall_base[i] = fall_cnt[i];
		end
	endtask

	task automatic check_bursts(input int fired);
		int got_n;
		int exp_n;
		logic exp_rest;
		for (int i = 0; i < num_chan; i++) begin
			exp_rest = (model_type[i] == TRIG_LOW);
			exp_n = (i == fired) ? expected_pulses(i) : 0;
			if (exp_rest) begin
				got_n = fall_cnt[i] - fall_base[i]; // pulses leave a high rest.
			end else begin
				got_n = rise_cnt[i] - rise_base[i];
			end
			check_pulses(i, got_n, exp_n, trig_out[i], exp_rest);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		int n;
		n = main_errors + reply_errors - err_before;
		if (n == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, n);
		end
	endtask

	task automatic test_reset();
		int err0;
		err0 = main_errors + reply_errors;
		@(negedge clk);
		main_checks++;
		if (tx !== 1'b1) begin
			main_errors++;
			$display("FAIL tx: got 0x%0h, expected 0x1", tx);
		end
		for (int i = 0; i < num_chan; i++) begin
			check_pulses(i, rise_cnt[i] + fall_cnt[i], 0, trig_out[i], 1'b0);
		end
		check_vector(vctr_out, '0);
		report_test("reset", err0);
	endtask

	task automatic test_write_read();
		int err0;
		err0 = main_errors + reply_errors;
		for (int ch = 0; ch < num_chan; ch++) begin
			rng_state = xorshift32(rng_state);
			run_frame(OP_WRITE, 8'(ch), rng_state[7:0], rng_state[15:8]);
		end
		check_vector(vctr_out, model_vec);
		for (int ch = 0; ch < num_chan; ch++) begin
			run_frame(OP_READ, 8'(ch), 8'h00, 8'h00);
		end
		report_test("write and read", err0);
	endtask

	task automatic test_high_burst(output int ch);
		int err0;
		logic [7:0] count;
		err0 = main_errors + reply_errors;
		rng_state = xorshift32(rng_state);
		ch = int'(rng_state[1:0]);
		count = 8'(32'd1 + rng_state[31:8] % 32'd6);
		run_frame(OP_CONFIG, 8'(ch), 8'(TRIG_HIGH), count);
		snapshot_edges();
		run_frame(OP_FIRE, 8'(ch), 8'h00, 8'h00);
		wait_quiet();
		check_bursts(ch);
		report_test("high pulse burst", err0);
	endtask

	task automatic test_low_burst(input int ch_high);
		int err0;
		int ch;
		int ch_off;
		logic [7:0] count;
		err0 = main_errors + reply_errors;
		ch = (ch_high + 1) % num_chan;
		ch_off = (ch_high + 2) % num_chan; // off type with a real count.
		rng_state = xorshift32(rng_state);
		count = 8'(32'd1 + rng_state[31:8] % 32'd6);
		snapshot_edges();
		run_frame(OP_CONFIG, 8'(ch), 8'(TRIG_LOW), count);
		wait_quiet();
		check_bursts(-1);
		snapshot_edges();
		run_frame(OP_FIRE, 8'(ch), 8'h00, 8'h00);
		wait_quiet();
		check_bursts(ch);
		run_frame(OP_CONFIG, 8'(ch_off), 8'(TRIG_OFF), count);
		snapshot_edges();
		run_frame(OP_FIRE, 8'(ch_off), 8'h00, 8'h00);
		wait_quiet();
		check_bursts(ch_off);
		report_test("low pulse burst", err0);
	endtask

	task automatic test_invalid();
		int err0;
		err0 = main_errors + reply_errors;
		rng_state = xorshift32(rng_state);
		run_frame(8'h7E, 8'd1, rng_state[7:0], rng_state[15:8]);
		run_frame(OP_WRITE, 8'd4, rng_state[23:16], 8'h00);
		run_frame(OP_CONFIG, 8'd2, 8'd3, 8'd2);
		for (int ch = 0; ch < num_chan; ch++) begin
			run_frame(OP_READ, 8'(ch), 8'h00, 8'h00);
		end
		check_vector(vctr_out, model_vec);
		report_test("invalid frames", err0);
	endtask

	initial begin : watchdog
		int cycle_cnt;
		cycle_cnt = 0;
		while (cycle_cnt < timeout_cycles) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles, the run was stopped", cycle_cnt);
		$display("Checks failed");
		$finish;
	end

	initial begin : main
		int ch_high;
		nrst = 1'b0;
		rx = 1'b1;
		rng_state = 32'h3673_6081;
		model_vec = '0;
		for (int i = 0; i < num_chan; i++) begin
			model_type[i] = TRIG_OFF;
			model_count[i] = 8'd0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
		test_reset();
		test_write_read();
		test_high_burst(ch_high);
		test_low_burst(ch_high);
		test_invalid();
		$display("checks %0d, errors %0d", main_checks + reply_checks,
			main_errors + reply_errors);
		if (main_errors + reply_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/trig_ctrl_top.sv
`default_nettype none
`timescale 1ns/100ps

module trig_ctrl_top #(
	parameter int clks_per_bit = 1250,
	parameter int pulse_div = 96
) (
	input wire clk,
	input wire nrst,
	input wire rx,
	output logic tx,
	output logic [trig_pkg::num_chan-1:0] trig_out,
	output trig_pkg::vctr_t vctr_out
);

	import trig_pkg::*;

	logic byte_valid;
	logic [7:0] rx_byte;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic tx_valid;
	logic [7:0] tx_byte;
	logic tx_ready;
	chan_cfg_t [num_chan-1:0] chan_cfg;
	logic [num_chan-1:0] fire;

	uart_rx #(.clks_per_bit(clks_per_bit)) i_rx (
		.clk(clk),
		.nrst(nrst),
		.rx(rx),
		.byte_valid(byte_valid),
		.rx_byte(rx_byte)
	);

	cmd_parser i_parser (
		.clk(clk),
		.nrst(nrst),
		.byte_valid(byte_valid),
		.rx_byte(rx_byte),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.tx_valid(tx_valid),
		.tx_byte(tx_byte),
		.tx_ready(tx_ready)
	);

	uart_tx #(.clks_per_bit(clks_per_bit)) i_tx (
		.clk(clk),
		.nrst(nrst),
		.tx_valid(tx_valid),
		.tx_byte(tx_byte),
		.tx_ready(tx_ready),
		.tx(tx)
	);

	trig_regs i_regs (
		.clk(clk),
		.nrst(nrst),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.chan_cfg(chan_cfg),
		.vctr(vctr_out),
		.fire(fire)
	);

	pulse_gen #(.pulse_div(pulse_div)) i_pulse (
		.clk(clk),
		.nrst(nrst),
		.chan_cfg(chan_cfg),
		.fire(fire),
		.trig_out(trig_out)
	);

endmodule

`default_nettype wire

//--- verilog/pulse_gen.sv
`default_nettype none
`timescale 1ns/100ps

module pulse_gen #(
	parameter int pulse_div = 96
) (
	input wire clk,
	input wire nrst,
	input wire trig_pkg::chan_cfg_t [trig_pkg::num_chan-1:0] chan_cfg,
	input wire [trig_pkg::num_chan-1:0] fire,
	output logic [trig_pkg::num_chan-1:0] trig_out
);

	import trig_pkg::*;

	localparam int div_w = $clog2(pulse_div);

	logic [div_w-1:0] div_cnt;
	logic tick;
	logic [num_chan-1:0] busy;
	logic [3:0] phase [num_chan]; // 0..4 active, 5..8 inactive.
	logic [7:0] remain [num_chan];

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			div_cnt <= '0;
			tick <= 1'b0;
		end else if (div_cnt == div_w'(pulse_div - 1)) begin
			div_cnt <= '0;
			tick <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			tick <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			busy <= '0;
			trig_out <= '0;
			for (int i = 0; i < num_chan; i++) begin
				phase[i] <= '0;
				remain[i] <= '0;
			end
		end else begin
			for (int i = 0; i < num_chan; i++) begin
				if (!busy[i]) begin
					if (fire[i] && chan_cfg[i].trig_type != TRIG_OFF &&
						chan_cfg[i].count != 8'd0) begin
						busy[i] <= 1'b1;
						phase[i] <= 4'd8; // parked, first tick starts pulse one.
						remain[i] <= chan_cfg[i].count;
					end
				end else if (tick) begin
					if (phase[i] != 4'd8) begin
						phase[i] <= phase[i] + 1'b1;
					end else if (remain[i] == 8'd0) begin
						busy[i] <= 1'b0;
					end else begin
						remain[i] <= remain[i] - 1'b1;
						phase[i] <= 4'd0;
					end
				end
				// low type inverts both pulse and rest level
				trig_out[i] <= (busy[i] && phase[i] < 4'd5) ^ (chan_cfg[i].trig_type == TRIG_LOW);
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/trig_regs.sv
`default_nettype none
`timescale 1ns/100ps

module trig_regs (
	input wire clk,
	input wire nrst,
	input wire trig_pkg::wb_req_t wb_req,
	output trig_pkg::wb_rsp_t wb_rsp,
	output trig_pkg::chan_cfg_t [trig_pkg::num_chan-1:0] chan_cfg,
	output trig_pkg::vctr_t vctr,
	output logic [trig_pkg::num_chan-1:0] fire
);

	import trig_pkg::*;

	logic [1:0] chan;
	reg_field_e field;
	logic req;
	logic ack;

	assign chan = wb_req.adr[3:2];
	assign field = reg_field_e'(wb_req.adr[1:0]);
	assign req = wb_req.cyc & wb_req.stb & ~ack; // new request, not yet acked.

	assign wb_rsp.ack = ack;
	assign wb_rsp.dat = vctr[chan];

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			ack <= 1'b0;
			fire <= '0;
			chan_cfg <= '0;
			vctr <= '0;
		end else begin
			ack <= req;
			fire <= '0;
			if (req && wb_req.we && field == FIELD_FIRE) begin
				fire[chan] <= 1'b1; // lines up with ack.
			end
			if (ack && wb_req.we) begin
				case (field)
					FIELD_TYPE: chan_cfg[chan].trig_type <= trig_type_e'(wb_req.dat[1:0]);
					FIELD_COUNT: chan_cfg[chan].count <= wb_req.dat;
					FIELD_VECTOR: vctr[chan] <= wb_req.dat;
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/cmd_parser.sv
`default_nettype none
`timescale 1ns/100ps

module cmd_parser (
	input wire clk,
	input wire nrst,
	input wire byte_valid,
	input wire [7:0] rx_byte,
	output trig_pkg::wb_req_t wb_req,
	input wire trig_pkg::wb_rsp_t wb_rsp,
	output logic tx_valid,
	output logic [7:0] tx_byte,
	input wire tx_ready
);

	import trig_pkg::*;

	parse_state_e state;
	logic [3:0][7:0] frame; // opcode, channel, arg1, arg2.
	logic [1:0] byte_cnt;
	logic step; // second bus cycle of a CONFIG.
	logic [7:0] rd_data;
	logic [1:0] tx_idx;
	cmd_op_e op;
	logic frame_ok;
	logic last_step;
	reg_field_e req_field;
	logic req_we;
	logic [7:0] req_dat;
	logic [3:0][7:0] reply;

	assign op = cmd_op_e'(frame[0]);
	assign frame_ok = (op inside {OP_READ, OP_CONFIG, OP_FIRE, OP_WRITE}) &&
		(frame[1] < 8'(num_chan)) &&
		(op != OP_CONFIG || frame[2] < 8'd3);
	assign last_step = (op != OP_CONFIG) || step;

	always_comb begin
		req_we = 1'b1;
		req_dat = frame[2];
		req_field = FIELD_VECTOR;
		case (op)
			OP_CONFIG: begin
				req_field = step ? FIELD_COUNT : FIELD_TYPE;
				req_dat = step ? frame[3] : frame[2];
			end
			OP_FIRE: req_field = FIELD_FIRE;
			OP_READ: req_we = 1'b0;
			default: req_field = FIELD_VECTOR;
		endcase
	end

	always_comb begin
		if (!frame_ok) begin
			reply = {4{8'hFF}};
		end else if (op == OP_READ) begin
			reply = {8'h00, rd_data, frame[1], frame[0]};
		end else begin
			reply = frame; // plain echo.
		end
	end

	assign tx_byte = reply[tx_idx];

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			state <= COLLECT;
			byte_cnt <= '0;
			step <= 1'b0;
			tx_idx <= '0;
			tx_valid <= 1'b0;
			wb_req <= '0;
		end else begin
			case (state)
				COLLECT: begin
					if (byte_valid) begin
						byte_cnt <= byte_cnt + 1'b1;
						if (byte_cnt == 2'd3) begin
							state <= BUS;
							step <= 1'b0;
						end
					end
				end
				BUS: begin
					if (!frame_ok) begin
						state <= REPLY; // no bus cycle for a bad frame.
						tx_valid <= 1'b1;
						tx_idx <= '0;
					end else if (!wb_req.cyc) begin
						wb_req.cyc <= 1'b1;
						wb_req.stb <= 1'b1;
						wb_req.we <= req_we;
						wb_req.adr <= {frame[1][1:0], req_field};
						wb_req.dat <= req_dat;
					end else if (wb_rsp.ack) begin
						wb_req.cyc <= 1'b0;
						wb_req.stb <= 1'b0;
						step <= 1'b1;
						if (last_step) begin
							state <= REPLY;
							tx_valid <= 1'b1;
							tx_idx <= '0;
						end
					end
				end
				REPLY: begin
					if (tx_valid && tx_ready) begin
						tx_idx <= tx_idx + 1'b1;
						if (tx_idx == 2'd3) begin
							tx_valid <= 1'b0;
							state <= COLLECT;
						end
					end
				end
				default: state <= COLLECT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == COLLECT && byte_valid) begin
			frame[byte_cnt] <= rx_byte;
		end
		if (state == BUS && wb_req.cyc && wb_rsp.ack && !wb_req.we) begin
			rd_data <= wb_rsp.dat; // read data is only valid with ack.
		end
	end

endmodule

`default_nettype wire

//--- verilog/uart_tx.sv
`default_nettype none
`timescale 1ns/100ps

module uart_tx #(
	parameter int clks_per_bit = 1250
) (
	input wire clk,
	input wire nrst,
	input wire tx_valid,
	input wire [7:0] tx_byte,
	output logic tx_ready,
	output logic tx
);

	localparam int cnt_w = $clog2(clks_per_bit);

	logic [9:0] frame_q; // stop, data, start; bit 0 is on the line.
	logic [3:0] bit_idx;
	logic [cnt_w-1:0] cnt;
	logic busy;

	assign tx_ready = ~busy;
	assign tx = frame_q[0];

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			frame_q <= '1;
			bit_idx <= '0;
			cnt <= '0;
			busy <= 1'b0;
		end else if (!busy) begin
			if (tx_valid) begin
				frame_q <= {1'b1, tx_byte, 1'b0};
				bit_idx <= '0;
				cnt <= '0;
				busy <= 1'b1;
			end
		end else if (cnt != cnt_w'(clks_per_bit - 1)) begin
			cnt <= cnt + 1'b1;
		end else begin
			cnt <= '0;
			frame_q <= {1'b1, frame_q[9:1]}; // shift in idle level behind the frame.
			bit_idx <= bit_idx + 1'b1;
			if (bit_idx == 4'd9) begin
				busy <= 1'b0; // stop bit done.
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/uart_rx.sv
`default_nettype none
`timescale 1ns/100ps

module uart_rx #(
	parameter int clks_per_bit = 1250
) (
	input wire clk,
	input wire nrst,
	input wire rx,
	output logic byte_valid,
	output logic [7:0] rx_byte
);

	localparam int cnt_w = $clog2(clks_per_bit);

	logic [2:0] rx_sync; // two sync flops plus one for edge detect.
	logic rx_s;
	logic start_edge;
	logic active;
	logic [3:0] bit_idx; // 0 start, 1..8 data, 9 stop.
	logic [cnt_w-1:0] cnt;
	logic [7:0] shift_q;
	logic sample;

	assign rx_s = rx_sync[1];
	assign start_edge = rx_sync[2] & ~rx_sync[1];
	assign sample = active && (cnt == '0);
	assign rx_byte = shift_q;

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			rx_sync <= 3'b111;
			active <= 1'b0;
			bit_idx <= '0;
			cnt <= '0;
			byte_valid <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[1:0], rx};
			byte_valid <= 1'b0;
			if (!active) begin
				if (start_edge) begin
					active <= 1'b1;
					bit_idx <= '0;
					cnt <= cnt_w'(clks_per_bit / 2 - 1); // first sample lands mid start bit.
				end
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1;
			end else begin
				cnt <= cnt_w'(clks_per_bit - 1);
				bit_idx <= bit_idx + 1'b1;
				if (bit_idx == 4'd0 && rx_s) begin
					active <= 1'b0; // line went back high, not a real start.
				end else if (bit_idx == 4'd9) begin
					active <= 1'b0;
					byte_valid <= rx_s; // framing error drops the byte.
				end
			end
		end
	end

	// data bits arrive lsb first
	always_ff @(posedge clk) begin
		if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
			shift_q <= {rx_s, shift_q[7:1]};
		end
	end

endmodule

`default_nettype wire

//--- verilog/trig_pkg.sv
`default_nettype none

package trig_pkg;

	localparam int num_chan = 4;

	typedef enum logic [7:0] {
		OP_READ   = 8'h00,
		OP_CONFIG = 8'h53,
		OP_FIRE   = 8'h5C,
		OP_WRITE  = 8'hA5
	} cmd_op_e;

	typedef enum logic [1:0] {
		TRIG_OFF  = 2'd0,
		TRIG_HIGH = 2'd1, // active-high pulses.
		TRIG_LOW  = 2'd2  // active-low pulses.
	} trig_type_e;

	typedef enum logic [1:0] {
		FIELD_TYPE   = 2'd0,
		FIELD_COUNT  = 2'd1,
		FIELD_VECTOR = 2'd2,
		FIELD_FIRE   = 2'd3
	} reg_field_e;

	typedef enum logic [1:0] {
		COLLECT,
		BUS,
		REPLY
	} parse_state_e;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [3:0] adr; // channel in [3:2], field in [1:0].
		logic [7:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [7:0] dat;
	} wb_rsp_t;

	typedef struct packed {
		trig_type_e trig_type;
		logic [7:0] count;
	} chan_cfg_t;

	typedef logic [num_chan-1:0][7:0] vctr_t;

endpackage

`default_nettype wire
